//--- dma_sched_top.f
+incdir+.
dma_sched_pkg.sv
desc_mem.sv
desc_decode.sv
block_execute.sv
desc_result.sv
dma_sched_top.sv
tb_clkgen.sv
dma_sched_props.sv
tb_dma_sched.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DMA scheduler testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_sched \
  -f dma_sched_top.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

//--- tb_dma_sched.sv
`default_nettype none
`timescale 1ns/100ps

`include "dma_sched_consts.svh"

module tb_dma_sched;
  import dma_sched_pkg::*;

  typedef struct {
    int    slot;
    addr_t addr;
    int    len;
    bit    irq_en;
    int    stop_at;  // 0 = mover sends everything
    int    slot2;    // -1 = single slot
    addr_t addr2;
    int    ncnt;
    int    cnts [3];
  } row_t;

  logic        CLK, RST;
  logic        psel, penable, pwrite;
  logic [`DS_APB_AW-1:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, blk_issue, blk_done, blk_stop, irq, irq_err;
  addr_t       blk_addr;
  cnt_t        blk_count, blk_sent;
  slot_t       irq_slot;

  row_t        rows [4];
  int          errors, failed, issue_cnt, irq_cnt;
  slot_t       last_irq_slot;
  logic        last_irq_err;
  logic [31:0] seed;

  tb_clkgen i_clkgen (.CLK, .RST);

  dma_sched_top i_dma_sched_top (
    .CLK, .RST, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .blk_issue, .blk_addr, .blk_count, .blk_done, .blk_sent, .blk_stop,
    .irq, .irq_slot, .irq_err
  );

  // event counters, sampled mid-cycle
  always @(negedge CLK)
  begin
    if (blk_issue)
      issue_cnt++;
    if (irq)
    begin
      irq_cnt++;
      last_irq_slot = irq_slot;
      last_irq_err  = irq_err;
    end
  end

  function automatic int next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[30:16]);
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_access(logic wr, logic [`DS_APB_AW-1:0] a, logic [31:0] d,
                            output logic [31:0] rd);
    int t;
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    penable = 1'b0;
    @(posedge CLK);
    #1 penable = 1'b1;
    for (t = 0; t < 10; t++)
    begin
      @(negedge CLK);
      if (pready)
        break;
      @(posedge CLK);
    end
    if (t == 10)
    begin
      $display("APB access to %h never got pready", a);
      errors++;
    end
    rd = prdata;
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // pulse is counted at the negedge, picked up at the next posedge
  task automatic wait_issue(inout int seen, output bit ok);
    ok = 1'b0;
    for (int t = 0; t < 200; t++)
    begin
      @(posedge CLK);
      if (issue_cnt != seen)
      begin
        seen++;
        ok = 1'b1;
        break;
      end
    end
    if (!ok)
    begin
      $display("no blk_issue within 200 cycles");
      errors++;
    end
  endtask

  // mover answers 1 to 8 cycles later
  task automatic respond_block(cnt_t sent, logic stop);
    int d;
    d = 1 + (next_rand() % 8);
    repeat (d) @(posedge CLK);
    #1;
    blk_done = 1'b1;
    blk_sent = sent;
    blk_stop = stop;
    @(posedge CLK);
    #1;
    blk_done = 1'b0;
    blk_sent = '0;
    blk_stop = 1'b0;
  endtask

  task automatic run_row(row_t r);
    int    ns, k, prev, sl [2], idx [2];
    addr_t cur [2];
    len_t  rem [2];
    int    irq0, sent, seen;
    bit    ok;
    logic [31:0] rd;
    ns = (r.slot2 < 0) ? 1 : 2;
    sl[0] = r.slot;
    sl[1] = r.slot2;
    cur[0] = r.addr;
    cur[1] = r.addr2;
    rem[0] = len_t'(r.len);
    rem[1] = len_t'(r.len);
    idx[0] = 0;
    idx[1] = 0;
    prev = -1;
    irq0 = irq_cnt;
    seen = issue_cnt;
    for (int i = 0; i < ns; i++)
      apb_access(1'b1, `DS_APB_AW'(sl[i] * 8), cur[i], rd);
    for (int i = 0; i < ns; i++)
      apb_access(1'b1, `DS_APB_AW'(sl[i] * 8 + 4), {1'b1, r.irq_en, 6'b0, rem[i]}, rd);
    for (int b = 0; b < r.ncnt * ns; b++)
    begin
      wait_issue(seen, ok);
      if (!ok)
        break;
      if (blk_addr == cur[0] && idx[0] < r.ncnt)
        k = 0;
      else if (ns == 2 && blk_addr == cur[1] && idx[1] < r.ncnt)
        k = 1;
      else
      begin
        $display("[FAIL] blk_addr got %h, no descriptor expects it", blk_addr);
        errors++;
        break;
      end
      check_val("blk_count", 32'(blk_count), 32'(r.cnts[idx[k]]));
      if (ns == 2 && k == prev && idx[1-k] < r.ncnt)
      begin
        $display("slot %0d served twice in a row while the other slot waited", sl[k]);
        errors++;
      end
      sent = (r.stop_at != 0) ? r.stop_at : int'(blk_count);
      respond_block(cnt_t'(sent), r.stop_at != 0);
      cur[k] += addr_t'(sent);
      rem[k] -= len_t'(sent);
      idx[k]++;
      prev = k;
    end
    for (int i = 0; i < ns; i++)
    begin
      for (int t = 0; t < 40; t++)
      begin
        apb_access(1'b0, `DS_APB_AW'(sl[i] * 8 + 4), '0, rd);
        if (!rd[31])
          break;
      end
      check_val("desc_hi", rd, {1'b0, r.irq_en, 6'b0, rem[i]});
      apb_access(1'b0, `DS_APB_AW'(sl[i] * 8), '0, rd);
      check_val("desc_lo", rd, cur[i]);
    end
    check_val("irq_count", 32'(irq_cnt - irq0), r.irq_en ? 32'(ns) : 32'd0);
    if (r.irq_en && ns == 1)
    begin
      check_val("irq_slot", 32'(last_irq_slot), 32'(r.slot));
      check_val("irq_err", 32'(last_irq_err), 32'(r.stop_at != 0));
    end
  endtask

  initial
  begin
    int          e0, n0, prop_fails;
    logic [31:0] rd;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    blk_done = 1'b0;
    blk_sent = '0;
    blk_stop = 1'b0;
    errors    = 0;
    failed    = 0;
    issue_cnt = 0;
    irq_cnt   = 0;
    seed      = 32'd61879;

    // slot, addr, len, irq_en, stop, slot2, addr2, block counts
    rows[0] = '{2, 32'h0000_1064, 40,  1'b1, 0,  -1, 32'h0, 1, '{40, 0, 0}};
    rows[1] = '{5, 32'h0000_1ff6, 100, 1'b1, 0,  -1, 32'h0, 3, '{10, 64, 26}};
    rows[2] = '{6, 32'h0000_0300, 40,  1'b1, 15, -1, 32'h0, 1, '{40, 0, 0}};
    rows[3] = '{1, 32'h0000_0100, 128, 1'b0, 0,  7, 32'h0000_0800, 2, '{64, 64, 0}};

    for (int t = 0; t < 20 && RST !== 1'b1; t++)
      @(posedge CLK);
    if (RST !== 1'b1)
    begin
      $display("reset never released");
      errors++;
    end

    // reset state
    e0 = errors;
    for (int a = 0; a < 2 * `DS_SLOTS; a++)
    begin
      apb_access(1'b0, `DS_APB_AW'(a * 4), '0, rd);
      check_val("prdata", rd, 32'h0);
    end
    check_val("blk_issue_count", 32'(issue_cnt), 32'h0);
    check_val("irq_count", 32'(irq_cnt), 32'h0);
    $display("test 1 reset state: %s", (errors == e0) ? "ok" : "FAILED");
    failed += (errors != e0);

    // inactive descriptor
    e0 = errors;
    n0 = issue_cnt;
    apb_access(1'b1, 6'h18, 32'h1234_5678, rd);
    apb_access(1'b1, 6'h1c, 32'h4000_0abc, rd);
    apb_access(1'b0, 6'h18, '0, rd);
    check_val("desc_lo", rd, 32'h1234_5678);
    apb_access(1'b0, 6'h1c, '0, rd);
    check_val("desc_hi", rd, 32'h4000_0abc);
    repeat (30) @(posedge CLK);
    check_val("blk_issue_count", 32'(issue_cnt - n0), 32'h0);
    $display("test 2 inactive descriptor: %s", (errors == e0) ? "ok" : "FAILED");
    failed += (errors != e0);

    for (int r = 0; r < 4; r++)
    begin
      e0 = errors;
      run_row(rows[r]);
      $display("test %0d slot %0d: %s", r + 3, rows[r].slot, (errors == e0) ? "ok" : "FAILED");
      failed += (errors != e0);
    end

    prop_fails = i_dma_sched_top.i_dma_sched_props.fail_cnt;
    $display("tests 6, failed %0d, errors %0d, assertion failures %0d",
             failed, errors, prop_fails);
    if (errors == 0 && prop_fails == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_sched_props.sv
`default_nettype none
`timescale 1ns/100ps

module dma_sched_props (
  input wire                      CLK,
  input wire                      RST,
  input wire                      blk_issue,
  input wire                      blk_done,
  input wire                      irq,
  input wire dma_sched_pkg::cmd_t cmd,
  input wire                      cmd_valid,
  input wire                      cmd_ready
);
  import dma_sched_pkg::*;

  logic pending;  // block out at the mover
  int   fail_cnt = 0;

  always_ff @(posedge CLK)
  begin
    if (!RST)
      pending <= 1'b0;
    else if (blk_issue)
      pending <= 1'b1;
    else if (blk_done)
      pending <= 1'b0;
  end

  issue_pulse: assert property (@(posedge CLK) disable iff (!RST) blk_issue |=> !blk_issue)
  else
  begin
    fail_cnt++;
    $error("blk_issue longer than one cycle");
  end

  irq_pulse: assert property (@(posedge CLK) disable iff (!RST) irq |=> !irq)
  else
  begin
    fail_cnt++;
    $error("irq longer than one cycle");
  end

  // held through the wait and the handshake cycle
  cmd_hold: assert property (@(posedge CLK) disable iff (!RST)
    cmd_valid |=> $stable(cmd))
  else
  begin
    fail_cnt++;
    $error("cmd changed while cmd_valid was high");
  end

  one_block: assert property (@(posedge CLK) disable iff (!RST) blk_issue |-> !pending)
  else
  begin
    fail_cnt++;
    $error("blk_issue before blk_done of the previous block");
  end

endmodule

bind dma_sched_top dma_sched_props i_dma_sched_props (
  .CLK(CLK), .RST(RST), .blk_issue(blk_issue), .blk_done(blk_done), .irq(irq),
  .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
);

`default_nettype wire

//--- tb_clkgen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen (
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

  initial
  begin
    RST = 1'b0;
    repeat (5) @(posedge CLK);
    #1 RST = 1'b1;
  end

endmodule

`default_nettype wire

//--- dma_sched_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "dma_sched_consts.svh"

module dma_sched_top (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [`DS_APB_AW-1:0]      paddr,
  input  wire [31:0]                pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      blk_issue,
  output dma_sched_pkg::addr_t      blk_addr,
  output dma_sched_pkg::cnt_t       blk_count,
  input  wire                       blk_done,
  input  wire dma_sched_pkg::cnt_t  blk_sent,
  input  wire                       blk_stop,
  output logic                      irq,
  output dma_sched_pkg::slot_t      irq_slot,
  output logic                      irq_err
);
  import dma_sched_pkg::*;

  slot_t    rd_slot;
  desc_t    rd_desc;
  cmd_t     cmd;
  logic     cmd_valid;
  logic     cmd_ready;
  outcome_t res;
  logic     res_valid;
  logic     wr_en;
  slot_t    wr_slot;
  desc_t    wr_desc;
  logic     wb_release;

  desc_mem i_desc_mem (
    .CLK, .RST,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .rd_slot, .rd_desc,
    .wr_en, .wr_slot, .wr_desc
  );

  desc_decode i_desc_decode (
    .CLK, .RST,
    .rd_desc, .cmd_ready, .wb_release,
    .rd_slot, .cmd, .cmd_valid
  );

  block_execute i_block_execute (
    .CLK, .RST,
    .cmd, .cmd_valid, .cmd_ready,
    .blk_issue, .blk_addr, .blk_count, .blk_done, .blk_sent, .blk_stop,
    .res, .res_valid
  );

  desc_result i_desc_result (
    .CLK, .RST,
    .res, .res_valid,
    .wr_en, .wr_slot, .wr_desc, .wb_release,
    .irq, .irq_slot, .irq_err
  );

endmodule

`default_nettype wire

//--- desc_result.sv
`default_nettype none
`timescale 1ns/100ps

module desc_result (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire dma_sched_pkg::outcome_t res,
  input  wire                          res_valid,
  output logic                         wr_en,
  output dma_sched_pkg::slot_t         wr_slot,
  output dma_sched_pkg::desc_t         wr_desc,
  output logic                         wb_release,
  output logic                         irq,
  output dma_sched_pkg::slot_t         irq_slot,
  output logic                         irq_err
);
  import dma_sched_pkg::*;

  len_t  new_len;
  addr_t new_addr;
  logic  closing;

  assign new_len  = res.len - len_t'(res.sent);
  assign new_addr = res.addr + addr_t'(res.sent);
  assign closing  = (new_len == '0) | res.stop;  // abrupt stop ends it too

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wr_en      <= 1'b0;
      wb_release <= 1'b0;
      irq        <= 1'b0;
    end
    else
    begin
      wr_en      <= res_valid;
      wb_release <= res_valid;
      irq        <= res_valid & closing & res.irq_en;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (res_valid)
    begin
      wr_slot        <= res.slot;
      wr_desc.active <= ~closing;
      wr_desc.irq_en <= res.irq_en;
      wr_desc.rsvd   <= '0;
      wr_desc.len    <= new_len;
      wr_desc.addr   <= new_addr;
      irq_slot       <= res.slot;
      irq_err        <= res.stop;
    end
  end

endmodule

`default_nettype wire

//--- block_execute.sv
`default_nettype none
`timescale 1ns/100ps

`include "dma_sched_consts.svh"

module block_execute (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire dma_sched_pkg::cmd_t cmd,
  input  wire                      cmd_valid,
  output logic                     cmd_ready,
  output logic                     blk_issue,
  output dma_sched_pkg::addr_t     blk_addr,
  output dma_sched_pkg::cnt_t      blk_count,
  input  wire                      blk_done,
  input  wire dma_sched_pkg::cnt_t blk_sent,
  input  wire                      blk_stop,
  output dma_sched_pkg::outcome_t  res,
  output logic                     res_valid
);
  import dma_sched_pkg::*;

  logic busy;
  logic accept;
  logic finish;

  // carried from the command to the outcome
  slot_t hold_slot;
  len_t  hold_len;
  logic  hold_irq_en;

  logic [`DS_PAGE_BITS:0] room;
  logic [`DS_PAGE_BITS:0] want;
  cnt_t                   first_cnt;

  assign cmd_ready = ~busy;
  assign accept    = cmd_valid & ~busy;
  assign finish    = busy & blk_done;

  // ---------------------------------------------------------------------------
  // page split
  // ---------------------------------------------------------------------------

  assign room = (`DS_PAGE_BITS + 1)'(`DS_PAGE_WORDS)
              - {1'b0, cmd.addr[`DS_PAGE_BITS-1:0]};
  assign want = {{(`DS_PAGE_BITS - 6){1'b0}}, cmd.cnt};

  // rest of the page is picked up when decode comes back to this slot
  assign first_cnt = (want > room) ? room[6:0] : cmd.cnt;

  // ---------------------------------------------------------------------------
  // issue and wait
  // ---------------------------------------------------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy      <= 1'b0;
      blk_issue <= 1'b0;
      res_valid <= 1'b0;
    end
    else
    begin
      blk_issue <= accept;
      res_valid <= finish;
      if (accept)
      begin
        busy <= 1'b1;
      end
      else if (finish)
      begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      blk_addr    <= cmd.addr;
      blk_count   <= first_cnt;
      hold_slot   <= cmd.slot;
      hold_len    <= cmd.len;
      hold_irq_en <= cmd.irq_en;
    end
    if (finish)
    begin
      res.slot   <= hold_slot;
      res.addr   <= blk_addr;
      res.len    <= hold_len;
      res.irq_en <= hold_irq_en;
      res.sent   <= blk_sent;  // mover's word, unchanged
      res.stop   <= blk_stop;
    end
  end

endmodule

`default_nettype wire

//--- desc_decode.sv
`default_nettype none
`timescale 1ns/100ps

`include "dma_sched_consts.svh"

module desc_decode (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire dma_sched_pkg::desc_t rd_desc,
  input  wire                       cmd_ready,
  input  wire                       wb_release,
  output dma_sched_pkg::slot_t      rd_slot,
  output dma_sched_pkg::cmd_t       cmd,
  output logic                      cmd_valid
);
  import dma_sched_pkg::*;

  dec_state_t state;
  slot_t      next_slot;
  cnt_t       blk_cnt;
  logic       take;

  assign next_slot = (rd_slot == slot_t'(`DS_SLOTS - 1)) ? '0 : rd_slot + 1'b1;

  // no more than one block's worth per command
  assign blk_cnt = (rd_desc.len > len_t'(`DS_MAX_BLOCK)) ? cnt_t'(`DS_MAX_BLOCK)
                                                         : rd_desc.len[6:0];

  assign take = (state == LOOK) && rd_desc.active;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= SCAN;
      rd_slot   <= '0;
      cmd_valid <= 1'b0;
    end
    else
    begin
      case (state)
        SCAN: state <= LOOK;  // rd_slot settles
        LOOK:
        begin
          if (rd_desc.active)
          begin
            cmd_valid <= 1'b1;
            state     <= HOLD;
          end
          else
          begin
            rd_slot <= next_slot;
            state   <= SCAN;
          end
        end
        HOLD:
        begin
          if (cmd_ready)
          begin
            cmd_valid <= 1'b0;
            state     <= WAIT;
          end
        end
        WAIT:
        begin
          // move on even if this slot is still active, keeps it fair
          if (wb_release)
          begin
            rd_slot <= next_slot;
            state   <= SCAN;
          end
        end
        default: state <= SCAN;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (take)
    begin
      cmd.slot   <= rd_slot;
      cmd.addr   <= rd_desc.addr;
      cmd.len    <= rd_desc.len;
      cmd.irq_en <= rd_desc.irq_en;
      cmd.cnt    <= blk_cnt;
    end
  end

endmodule

`default_nettype wire

//--- desc_mem.sv
`default_nettype none
`timescale 1ns/100ps

`include "dma_sched_consts.svh"

module desc_mem (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [`DS_APB_AW-1:0]      paddr,
  input  wire [31:0]                pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  input  wire dma_sched_pkg::slot_t rd_slot,
  output dma_sched_pkg::desc_t      rd_desc,
  input  wire                       wr_en,
  input  wire dma_sched_pkg::slot_t wr_slot,
  input  wire dma_sched_pkg::desc_t wr_desc
);
  import dma_sched_pkg::*;

  desc_t mem [`DS_SLOTS];

  slot_t apb_slot;
  logic  apb_hi;
  logic  access;

  assign apb_slot = paddr[5:3];
  assign apb_hi   = paddr[2];  // 1 = flags and length
  assign access   = psel & penable;

  // engine writeback wins, apb waits one cycle
  assign pready = ~(access & wr_en);

  assign prdata  = apb_hi ? mem[apb_slot][63:32] : mem[apb_slot][31:0];
  assign rd_desc = mem[rd_slot];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < `DS_SLOTS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      mem[wr_slot] <= wr_desc;
    end
    else if (access && pwrite)
    begin
      if (apb_hi)
      begin
        mem[apb_slot][63:32] <= pwdata;
      end
      else
      begin
        mem[apb_slot][31:0] <= pwdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- dma_sched_pkg.sv
`default_nettype none

package dma_sched_pkg;

  typedef logic [31:0] addr_t;  // word address
  typedef logic [23:0] len_t;   // remaining words
  typedef logic [2:0]  slot_t;
  typedef logic [6:0]  cnt_t;   // 0 .. 64

  // one descriptor slot, 64 bits, cpu sees it as two words
  typedef struct packed {
    logic       active;
    logic       irq_en;
    logic [5:0] rsvd;
    len_t       len;
    addr_t      addr;
  } desc_t;

  // len is the whole remaining length, cnt the clipped block
  typedef struct packed {
    slot_t slot;
    addr_t addr;
    len_t  len;
    logic  irq_en;
    cnt_t  cnt;
  } cmd_t;

  typedef struct packed {
    slot_t slot;
    addr_t addr;
    len_t  len;
    logic  irq_en;
    cnt_t  sent;  // as reported by the mover
    logic  stop;
  } outcome_t;

  typedef enum logic [1:0] {
    SCAN,
    LOOK,
    HOLD,
    WAIT
  } dec_state_t;

endpackage

`default_nettype wire

//--- dma_sched_consts.svh
`ifndef DMA_SCHED_CONSTS_SVH
`define DMA_SCHED_CONSTS_SVH

// ---------------------------------------------------------------------------
// descriptor store
// ---------------------------------------------------------------------------

`define DS_SLOTS 8

// apb byte address, slot in 5:3, word select in bit 2
`define DS_APB_AW 6

// ---------------------------------------------------------------------------
// block sizing
// ---------------------------------------------------------------------------

// longest single block handed to the mover, in words
`define DS_MAX_BLOCK 64

// page offset width; blocks never straddle a page
`define DS_PAGE_BITS 12
`define DS_PAGE_WORDS (1 << `DS_PAGE_BITS)

`endif
